// File: rtl/intr_pkg.sv
// Interrupt controller package
// Line and vector widths, grant state encoding and cfg bit positions

package intr_pkg;

  // ==========================================================================
  // Widths with a meaning
  // ==========================================================================

  // One bit per device line in a group
  typedef logic [7:0] line_vec_t;

  // Encoded line number, highest active line wins
  typedef logic [2:0] line_num_t;

  // Acknowledged vector {group, line}
  typedef logic [3:0] vector_t;

  // ==========================================================================
  // Grant state machine
  // ==========================================================================

  typedef enum logic [1:0] {
    grp_idle    = 2'b00,    // Nothing pending
    grp_pend    = 2'b01,    // Enabled request waiting for ack
    grp_granted = 2'b10     // Acked, held until line clears
  } grant_state_t;

  // ==========================================================================
  // Enable bit positions in cfg_data
  // ==========================================================================

  parameter int cfg_hi_bit = 1;   // High group enable
  parameter int cfg_lo_bit = 0;   // Low group enable

  // Vector bit 3 marks the high group
  parameter int vec_grp_bit = 3;

endpackage

// File: rtl/intr_if.sv
// Interfaces between controller blocks
// intr_req_if carries encoded requests, intr_grp_if carries one group's grant status

`timescale 1ns/10ps

// ============================================================================
// Encoded request levels from the input side
// ============================================================================
interface intr_req_if;

  logic                hi_det;    // Any high line active
  intr_pkg::line_num_t hi_num;    // Highest active high line
  logic                lo_det;    // Any low line active
  intr_pkg::line_num_t lo_num;    // Highest active low line

  // Synchroniser side
  modport src (
    output hi_det,
    output hi_num,
    output lo_det,
    output lo_num
  );

  // Group side
  modport dst (
    input hi_det,
    input hi_num,
    input lo_det,
    input lo_num
  );

endinterface

// ============================================================================
// Status of one priority group toward the output side
// ============================================================================
interface intr_grp_if;

  logic                rq;        // Group is pending
  logic                gas;       // Ack taken this cycle
  logic                gs_n;      // Low while granted
  intr_pkg::line_num_t num;       // Captured line number

  modport grp (output rq, output gas, output gs_n, output num);   // Group FSM side
  modport out (input rq, input gas, input gs_n, input num);       // Vector side

endinterface

// File: rtl/intr_sync.sv
// Input side of the interrupt controller
// Request synchronisers and registered priority encoders for both groups

`timescale 1ns/10ps

module intr_sync #(
  parameter int sync_stages = 2          // Synchroniser depth, 2 or 3
) (
  input  logic                mclk,
  input  logic                rst_n,
  input  intr_pkg::line_vec_t hi_req,    // Raw high group lines
  input  intr_pkg::line_vec_t lo_req,    // Raw low group lines
  intr_req_if.src             req        // Encoded request levels
);

  // ==========================================================================
  // Synchroniser chains
  // ==========================================================================

  intr_pkg::line_vec_t hi_q [sync_stages];   // High group stages
  intr_pkg::line_vec_t lo_q [sync_stages];   // Low group stages

  // Highest set line wins
  function automatic intr_pkg::line_num_t enc_highest(input intr_pkg::line_vec_t lines);
    intr_pkg::line_num_t num;
    num = '0;
    for (int i = 0; i < $bits(intr_pkg::line_vec_t); i++) begin
      if (lines[i]) begin
        num = intr_pkg::line_num_t'(i);     // Later lines overwrite lower ones
      end
    end
    return num;
  endfunction

  genvar s;
  generate
    for (s = 0; s < sync_stages; s++) begin : g_stage
      if (s == 0) begin : g_first
        always_ff @(posedge mclk) begin
          if (!rst_n) begin
            hi_q[s] <= '0;
            lo_q[s] <= '0;
          end else begin
            hi_q[s] <= hi_req;              // Asynchronous lines sampled here
            lo_q[s] <= lo_req;
          end
        end
      end else begin : g_next
        always_ff @(posedge mclk) begin
          if (!rst_n) begin
            hi_q[s] <= '0;
            lo_q[s] <= '0;
          end else begin
            hi_q[s] <= hi_q[s-1];           // Shift along the chain
            lo_q[s] <= lo_q[s-1];
          end
        end
      end
    end
  endgenerate

  // ==========================================================================
  // Registered priority encoders
  // ==========================================================================

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      req.hi_det <= 1'b0;
      req.hi_num <= '0;
      req.lo_det <= 1'b0;
      req.lo_num <= '0;
    end else begin
      req.hi_det <= |hi_q[sync_stages-1];                // Any high line
      req.hi_num <= enc_highest(hi_q[sync_stages-1]);
      req.lo_det <= |lo_q[sync_stages-1];                // Any low line
      req.lo_num <= enc_highest(lo_q[sync_stages-1]);
    end
  end

endmodule

// File: rtl/intr_group.sv
// Priority group of the interrupt controller
// Enable register and grant FSM for one group

`timescale 1ns/10ps

module intr_group #(
  parameter bit group_hi = 1'b1          // 1 for high group, 0 for low
) (
  input  logic       mclk,
  input  logic       rst_n,
  intr_req_if.dst    req,                // Encoded requests, both groups
  input  logic       cfg_wr,             // Enable write strobe
  input  logic [1:0] cfg_data,           // Enable bits
  input  logic       ack,                // CPU acknowledge strobe
  input  logic       block,              // Higher group busy
  intr_grp_if.grp    grp                 // Status toward output side
);

  // ==========================================================================
  // Group selection
  // ==========================================================================

  localparam int cfg_bit = group_hi ? intr_pkg::cfg_hi_bit : intr_pkg::cfg_lo_bit;

  logic                   enable;        // Group enable
  logic                   det;           // This group's detect
  intr_pkg::line_num_t    num_in;        // This group's encoded line
  intr_pkg::line_num_t    num_q;         // Captured line number
  intr_pkg::grant_state_t state;
  intr_pkg::grant_state_t state_nxt;
  logic                   take;          // Ack accepted this cycle

  assign det    = group_hi ? req.hi_det : req.lo_det;
  assign num_in = group_hi ? req.hi_num : req.lo_num;

  // ==========================================================================
  // Enable register
  // ==========================================================================

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      enable <= 1'b0;                     // Both groups start disabled
    end else if (cfg_wr) begin
      enable <= cfg_data[cfg_bit];        // Own bit only
    end
  end

  // ==========================================================================
  // Grant FSM
  // ==========================================================================

  // Pending, enabled, acked and no higher group in the way
  assign take = (state == intr_pkg::grp_pend) && enable && ack && !block;

  always_comb begin
    state_nxt = state;
    case (state)
      intr_pkg::grp_idle: begin
        if (det && enable) begin
          state_nxt = intr_pkg::grp_pend;       // Request seen and allowed
        end
      end
      intr_pkg::grp_pend: begin
        if (take) begin
          state_nxt = intr_pkg::grp_granted;
        end else if (!enable || !det) begin
          state_nxt = intr_pkg::grp_idle;       // Disabled or line withdrawn
        end
      end
      intr_pkg::grp_granted: begin
        if (!det) begin
          state_nxt = intr_pkg::grp_idle;       // Held until line clears
        end
      end
      default: begin
        state_nxt = intr_pkg::grp_idle;
      end
    endcase
  end

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      state <= intr_pkg::grp_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // Line number follows the encoder while pending, frozen once granted
  always_ff @(posedge mclk) begin
    if (state_nxt == intr_pkg::grp_pend) begin
      num_q <= num_in;
    end
  end

  // ==========================================================================
  // Status outputs
  // ==========================================================================

  assign grp.rq   = (state == intr_pkg::grp_pend);      // Feeds irq_n
  assign grp.gas  = take;                               // Single cycle with ack
  assign grp.gs_n = (state != intr_pkg::grp_granted);   // Active low grant
  assign grp.num  = num_q;

endmodule

// File: rtl/intr_vector_out.sv
// Output side of the interrupt controller
// IRQ gate, vector mux and registered vector with valid strobe

`timescale 1ns/10ps

module intr_vector_out (
  input  logic              mclk,
  input  logic              rst_n,
  intr_grp_if.out           hi,          // High group status
  intr_grp_if.out           lo,          // Low group status
  output logic              irq_n,       // Active low interrupt request
  output intr_pkg::vector_t vector,      // Acknowledged vector
  output logic              vec_valid    // One cycle after ack
);

  // ==========================================================================
  // IRQ gate
  // ==========================================================================

  // Low while either group is pending
  assign irq_n = ~(hi.rq | lo.rq);

  // ==========================================================================
  // Vector mux
  // ==========================================================================

  intr_pkg::vector_t vec_sel;            // Vector of the acked group
  logic              any_gas;            // Some group took the ack

  always_comb begin
    vec_sel = '0;
    if (hi.gas) begin
      vec_sel                       = {1'b0, hi.num};
      vec_sel[intr_pkg::vec_grp_bit] = 1'b1;   // High group marker
    end else if (lo.gas) begin
      vec_sel = {1'b0, lo.num};                // Bit 3 stays clear
    end
  end

  assign any_gas = hi.gas | lo.gas;

  // ==========================================================================
  // Vector register
  // ==========================================================================

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      vector    <= '0;
      vec_valid <= 1'b0;
    end else begin
      vec_valid <= any_gas;              // Ack without a pending group gives nothing
      if (any_gas) begin
        vector <= vec_sel;               // Held until the next grant
      end
    end
  end

endmodule

// File: rtl/intr_ctrl_top.sv
// Two-level interrupt controller top
// Input side, high and low group FSMs and output side

`timescale 1ns/10ps

module intr_ctrl_top #(
  parameter int sync_stages = 2               // Synchroniser depth
) (
  input  logic                mclk,
  input  logic                rst_n,
  input  intr_pkg::line_vec_t hi_req,         // High group request lines
  input  intr_pkg::line_vec_t lo_req,         // Low group request lines
  input  logic                cfg_wr,         // Enable write strobe
  input  logic [1:0]          cfg_data,       // {hi_en, lo_en}
  input  logic                ack,            // CPU acknowledge
  output logic                irq_n,          // Active low interrupt
  output intr_pkg::vector_t   vector,         // {group, line}
  output logic                vec_valid       // Vector strobe
);

  // ==========================================================================
  // Internal buses
  // ==========================================================================

  intr_req_if req_bus ();                     // Encoded requests
  intr_grp_if hi_grp ();                      // High group status
  intr_grp_if lo_grp ();                      // Low group status

  logic lo_block;                             // High group pending or granted

  // Low group waits while the high group is busy
  assign lo_block = hi_grp.rq | ~hi_grp.gs_n;

  // ==========================================================================
  // Input side
  // ==========================================================================

  intr_sync #(
    .sync_stages(sync_stages)
  ) u_sync (
    .mclk  (mclk),
    .rst_n (rst_n),
    .hi_req(hi_req),
    .lo_req(lo_req),
    .req   (req_bus.src)
  );

  // ==========================================================================
  // Priority groups
  // ==========================================================================

  intr_group #(
    .group_hi(1'b1)
  ) u_hi (
    .mclk    (mclk),
    .rst_n   (rst_n),
    .req     (req_bus.dst),
    .cfg_wr  (cfg_wr),
    .cfg_data(cfg_data),
    .ack     (ack),
    .block   (1'b0),                          // Nothing outranks high
    .grp     (hi_grp.grp)
  );

  intr_group #(
    .group_hi(1'b0)
  ) u_lo (
    .mclk    (mclk),
    .rst_n   (rst_n),
    .req     (req_bus.dst),
    .cfg_wr  (cfg_wr),
    .cfg_data(cfg_data),
    .ack     (ack),
    .block   (lo_block),
    .grp     (lo_grp.grp)
  );

  // ==========================================================================
  // Output side
  // ==========================================================================

  intr_vector_out u_out (
    .mclk     (mclk),
    .rst_n    (rst_n),
    .hi       (hi_grp.out),
    .lo       (lo_grp.out),
    .irq_n    (irq_n),
    .vector   (vector),
    .vec_valid(vec_valid)
  );

endmodule

// File: bench/intr_ctrl_tb.sv
// Testbench for the two-level interrupt controller
// Clock, reset, stimulus table with LFSR rows, reference model, watchdog and counts

`timescale 1ns/10ps

module intr_ctrl_tb;

  localparam int sync_stages  = 2;
  localparam int clk_period   = 40;                 // ns
  localparam int reset_cycles = 3;                  // Two low plus release
  localparam int latency      = sync_stages + 2;    // Request to irq_n, in cycles
  localparam int margin       = sync_stages + 4;    // Settling bound per row
  localparam int random_rows  = 8;

  // One table entry
  typedef struct packed {
    intr_pkg::line_vec_t hi_req;
    intr_pkg::line_vec_t lo_req;
    logic [1:0]          en;                        // {hi_en, lo_en}
    logic                do_ack;
    logic                exp_irq_n;                 // After settling, before ack
    logic                exp_valid;                 // Strobe one cycle after ack
    intr_pkg::vector_t   exp_vector;
  } row_t;

  logic                mclk;
  logic                rst_n;
  intr_pkg::line_vec_t hi_req;
  intr_pkg::line_vec_t lo_req;
  logic                cfg_wr;
  logic [1:0]          cfg_data;
  logic                ack;
  logic                irq_n;
  intr_pkg::vector_t   vector;
  logic                vec_valid;

  row_t        rows[$];
  string       names[$];
  bit          table_ready;
  logic [31:0] lfsr;
  int          row_errors;                          // Mismatches in current test
  int          tests_run;
  int          tests_failed;

  intr_ctrl_top #(
    .sync_stages(sync_stages)
  ) i_dut (
    .mclk     (mclk),
    .rst_n    (rst_n),
    .hi_req   (hi_req),
    .lo_req   (lo_req),
    .cfg_wr   (cfg_wr),
    .cfg_data (cfg_data),
    .ack      (ack),
    .irq_n    (irq_n),
    .vector   (vector),
    .vec_valid(vec_valid)
  );

  initial begin
    mclk = 1'b0;
    forever begin
      #(clk_period / 2) mclk = ~mclk;
    end
  end

  // ==========================================================================
  // Reference model and random source
  // ==========================================================================

  // Scan from the top line down, first set line wins
  function automatic intr_pkg::line_num_t highest_line(input intr_pkg::line_vec_t lines);
    intr_pkg::line_num_t num;
    bit                  found;
    num   = '0;
    found = 1'b0;
    for (int i = 7; i >= 0; i--) begin
      if (lines[i] && !found) begin
        num   = 3'(i);
        found = 1'b1;
      end
    end
    return num;
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[6:0], lfsr[0]};                   // One step per bit
    end
  endtask

  // ==========================================================================
  // Stimulus table
  // ==========================================================================

  task automatic add_row(input string name, input logic [7:0] hi, input logic [7:0] lo,
                         input logic [1:0] en, input logic do_ack, input logic exp_irq_n,
                         input logic exp_valid, input logic [3:0] exp_vector);
    row_t r;
    r.hi_req     = hi;
    r.lo_req     = lo;
    r.en         = en;
    r.do_ack     = do_ack;
    r.exp_irq_n  = exp_irq_n;
    r.exp_valid  = exp_valid;
    r.exp_vector = exp_vector;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // Random row then a clear row, so each draw starts from idle groups
  task automatic add_random_rows(input int count);
    logic [7:0] hi;
    logic [7:0] lo;
    logic [7:0] en;
    logic       hi_pend;
    logic       lo_pend;
    logic [3:0] vec;
    for (int i = 0; i < count; i++) begin
      draw_bits(8, hi);
      draw_bits(8, lo);
      draw_bits(2, en);
      hi_pend = en[1] && (hi != 8'h00);
      lo_pend = en[0] && (lo != 8'h00);
      vec     = 4'h0;
      if (hi_pend) begin
        vec = {1'b1, highest_line(hi)};             // High group always wins
      end else if (lo_pend) begin
        vec = {1'b0, highest_line(lo)};
      end
      add_row("random", hi, lo, en[1:0], 1'b1, !(hi_pend || lo_pend), hi_pend || lo_pend, vec);
      add_row("random clear", 8'h00, 8'h00, 2'b00, 1'b0, 1'b1, 1'b0, 4'h0);
    end
  endtask

  task automatic build_table();
    add_row("both disabled", 8'h10, 8'h01, 2'b00, 1'b0, 1'b1, 1'b0, 4'h0);
    add_row("ack nothing pending", 8'h10, 8'h01, 2'b00, 1'b1, 1'b1, 1'b0, 4'h0);
    add_row("clear", 8'h00, 8'h00, 2'b10, 1'b0, 1'b1, 1'b0, 4'h0);
    add_row("single high", 8'h20, 8'h00, 2'b10, 1'b1, 1'b0, 1'b1, 4'hd);
    add_row("clear", 8'h00, 8'h00, 2'b10, 1'b0, 1'b1, 1'b0, 4'h0);
    add_row("line priority hi", 8'h4a, 8'h00, 2'b10, 1'b1, 1'b0, 1'b1, 4'he);
    add_row("clear", 8'h00, 8'h00, 2'b01, 1'b0, 1'b1, 1'b0, 4'h0);
    add_row("line priority lo", 8'h00, 8'h13, 2'b01, 1'b1, 1'b0, 1'b1, 4'h4);
    add_row("clear", 8'h00, 8'h00, 2'b11, 1'b0, 1'b1, 1'b0, 4'h0);
    add_row("group first ack", 8'h04, 8'h80, 2'b11, 1'b1, 1'b0, 1'b1, 4'ha);
    add_row("group held ack", 8'h04, 8'h80, 2'b11, 1'b1, 1'b0, 1'b0, 4'h0);
    add_row("group low ack", 8'h00, 8'h80, 2'b11, 1'b1, 1'b0, 1'b1, 4'h7);
    add_row("clear", 8'h00, 8'h00, 2'b11, 1'b0, 1'b1, 1'b0, 4'h0);
    add_row("low pending", 8'h00, 8'h08, 2'b01, 1'b0, 1'b0, 1'b0, 4'h0);
    add_row("low disabled", 8'h00, 8'h08, 2'b00, 1'b0, 1'b1, 1'b0, 4'h0);
    add_row("disabled low ack", 8'h00, 8'h08, 2'b00, 1'b1, 1'b1, 1'b0, 4'h0);
    add_row("disabled high ack", 8'h02, 8'h00, 2'b01, 1'b1, 1'b1, 1'b0, 4'h0);
    add_row("clear", 8'h00, 8'h00, 2'b00, 1'b0, 1'b1, 1'b0, 4'h0);
    add_random_rows(random_rows);
  endtask

  // ==========================================================================
  // Checking and row execution
  // ==========================================================================

  task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
      row_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (row_errors != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (row_errors == 0) ? "ok" : "mismatch");
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic run_row(input int idx);
    row_t r;
    int   cycles;
    r          = rows[idx];
    row_errors = 0;
    hi_req     = r.hi_req;
    lo_req     = r.lo_req;
    cfg_data   = r.en;
    cfg_wr     = 1'b1;                              // Enables rewritten every row
    @(negedge mclk);
    cfg_wr = 1'b0;
    cycles = 1;
    // Full pipeline latency first, then wait for irq_n up to the margin
    while (cycles < margin && (cycles < latency || irq_n !== r.exp_irq_n)) begin
      @(negedge mclk);
      cycles++;
    end
    check("irq_n", 8'(irq_n), 8'(r.exp_irq_n));
    check("vec_valid", 8'(vec_valid), 8'h00);       // No strobe without ack
    if (r.do_ack) begin
      ack = 1'b1;
      @(negedge mclk);
      ack = 1'b0;
      check("vec_valid", 8'(vec_valid), 8'(r.exp_valid));
      if (r.exp_valid) begin
        check("vector", 8'(vector), 8'(r.exp_vector));
      end
      @(negedge mclk);
      check("vec_valid", 8'(vec_valid), 8'h00);     // Single cycle strobe
    end
    finish_test(names[idx]);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    rst_n        = 1'b0;
    hi_req       = '0;
    lo_req       = '0;
    cfg_wr       = 1'b0;
    cfg_data     = 2'b00;
    ack          = 1'b0;
    lfsr         = 32'h7459;
    tests_run    = 0;
    tests_failed = 0;
    table_ready  = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge mclk);
    @(negedge mclk);
    rst_n      = 1'b1;
    row_errors = 0;
    check("irq_n", 8'(irq_n), 8'h01);               // Reset values
    check("vec_valid", 8'(vec_valid), 8'h00);
    check("vector", 8'(vector), 8'h00);
    finish_test("reset state");
    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end
    $display("tests run %0d, failed %0d", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(rows.size()) * (sync_stages + 8) * clk_period
               + reset_cycles * clk_period;
    #(limit_ns);
    $display("timeout: run did not finish within %0d ns", limit_ns);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: all.f
rtl/intr_pkg.sv
rtl/intr_if.sv
rtl/intr_sync.sv
rtl/intr_group.sv
rtl/intr_vector_out.sv
rtl/intr_ctrl_top.sv
bench/intr_ctrl_tb.sv

// File: Makefile
# Verilator simulation of the interrupt controller testbench

VERILATOR ?= verilator
TOP       ?= intr_ctrl_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
